// ==== build.f ====
rtl/chord_pkg.sv
rtl/chord_config.sv
rtl/voice_allocator.sv
rtl/sine_rom.sv
rtl/note_player.sv
rtl/sample_mixer.sv
rtl/chord_player.sv
testbench/chord_player_asserts.sv
testbench/tb_chord_player.sv

// ==== testbench/chord_trace.txt ====
# cfg_write cfg_data(hex pe,weight) load_new_note note duration activate beat generate_next_sample
# expected: note_done sample_ready final_sample, a dash skips that check
0 0 0 0  0 0 0 1  1 0 0      # request with nothing playing
0 0 0 0  0 0 0 0  - 0 0
1 4 0 0  0 0 0 0  1 0 0      # enable, weight 0
0 0 1 0  2 1 0 0  1 1 0      # chord timer gets 2 beats
0 0 1 1  4 1 0 0  1 0 0      # timer busy so voice 1 takes note 1
0 0 0 0  0 0 0 1  1 0 0
0 0 0 0  0 0 0 0  1 0 0
0 0 0 0  0 0 0 0  1 0 0
1 5 0 0  0 0 0 0  1 1 204    # weight 1 for the next sample
0 0 0 0  0 0 0 1  1 0 204
0 0 0 0  0 0 0 0  1 0 204
0 0 0 0  0 0 0 0  1 0 204
1 6 0 0  0 0 0 0  1 1 613
0 0 0 0  0 0 0 1  1 0 613
0 0 0 0  0 0 0 0  1 0 613
0 0 0 0  0 0 0 0  1 0 613
1 7 0 0  0 0 0 0  1 1 1327
0 0 0 0  0 0 0 1  1 0 1327
0 0 1 1  4 0 0 0  1 0 1327   # voice 2
0 0 1 1  4 0 0 0  1 0 1327   # voice 3
1 4 1 63 5 0 0 0  0 1 1326   # no slot left, dropped
0 0 0 0  0 0 0 1  0 0 1326
0 0 0 0  0 0 1 0  0 0 1326
0 0 0 0  0 0 0 0  0 0 1326
1 0 0 0  0 0 0 0  0 1 1429   # disable
0 0 0 0  0 0 0 1  0 0 1429
0 0 0 0  0 0 1 0  0 0 1429   # beat ignored while disabled
0 0 0 0  0 0 0 0  0 0 1429
1 4 0 0  0 0 0 0  0 1 0
0 0 0 0  0 0 0 1  0 0 0
0 0 0 0  0 0 1 0  0 0 0      # chord timer empties
0 0 0 0  0 0 0 0  1 0 0
0 0 0 0  0 0 1 0  1 1 2247   # voices frozen at 2
0 0 1 0  2 1 0 0  1 0 2247
0 0 0 0  0 0 0 0  0 0 2247
0 0 0 0  0 0 1 0  0 0 2247
0 0 0 0  0 0 0 0  0 0 2247
0 0 0 0  0 0 1 0  0 0 2247
0 0 0 0  0 0 0 0  1 0 2247

// ==== testbench/tb_chord_player.sv ====
`timescale 1ns/1ns

module tb_chord_player;
   import chord_pkg::*;

   localparam string trace_file   = "testbench/chord_trace.txt";
   localparam int    reset_cycles = 5;

   logic                    clk;
   logic                    arst_n;
   logic                    cfg_write;
   player_cfg_t             cfg_data;
   logic                    load_new_note;
   note_cmd_t               note_cmd;
   logic                    activate;
   logic                    beat;
   logic                    generate_next_sample;
   logic signed [mix_w-1:0] final_sample;
   logic                    sample_ready;
   logic                    note_done;

   string trace_lines [$];
   string exp_nd;
   string exp_sr;
   string exp_fs;
   int    errors;
   int    checks;
   int    assert_errors;
   int    cycles;
   int    cycle_limit;

   chord_player dut (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // Watchdog armed once the trace length is known
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, the trace did not run to its end", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   task automatic load_trace();
      int    fd;
      string line;
      fd = $fopen(trace_file, "r");
      if (fd == 0) begin
         $display("Error: cannot open trace file %s", trace_file);
         errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#") begin  // Skip column notes and blank lines
            trace_lines.push_back(line);
         end
      end
      $fclose(fd);
   endtask

   task automatic apply_line(input string line, output string nd, output string sr,
                             output string fs);
      int cw, cd, ln, nt, dr, act, bt, gen, n;
      n = $sscanf(line, "%d %h %d %d %d %d %d %d %s %s %s",
                  cw, cd, ln, nt, dr, act, bt, gen, nd, sr, fs);
      if (n != 11) begin
         $display("Error: malformed trace line at %0t: %s", $time, line);
         errors++;
      end
      cfg_write            <= cw[0];
      cfg_data             <= player_cfg_t'(cd[2:0]);
      load_new_note        <= ln[0];
      note_cmd             <= '{note: nt[note_w-1:0], duration: dr[dur_w-1:0]};
      activate             <= act[0];
      beat                 <= bt[0];
      generate_next_sample <= gen[0];
   endtask

   task automatic check_value(input string name, input string expected, input longint got);
      longint want;
      if (expected != "-") begin                     // Dash means no check this cycle
         void'($sscanf(expected, "%d", want));
         checks++;
         assert (got == want) else begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, want);
            errors++;
         end
      end
   endtask

   initial begin
      errors               = 0;
      checks               = 0;
      cycles               = 0;
      cycle_limit          = 0;
      arst_n               = 1'b0;
      cfg_write            = 1'b0;
      cfg_data             = '0;
      load_new_note        = 1'b0;
      note_cmd             = '0;
      activate             = 1'b0;
      beat                 = 1'b0;
      generate_next_sample = 1'b0;

      load_trace();
      if (trace_lines.size() == 0) begin
         $display("Error: trace file holds no stimulus lines");
         errors++;
      end
      cycle_limit = trace_lines.size() + reset_cycles + 20;

      repeat (reset_cycles) @(posedge clk);
      arst_n <= 1'b1;

      foreach (trace_lines[i]) begin
         @(posedge clk);
         apply_line(trace_lines[i], exp_nd, exp_sr, exp_fs);
         @(negedge clk);                               // Outputs settled mid cycle
         check_value("note_done", exp_nd, note_done);
         check_value("sample_ready", exp_sr, sample_ready);
         check_value("final_sample", exp_fs, final_sample);
      end
      @(posedge clk);

      assert_errors = dut.u_asserts.failures;
      $display("Errors: %0d in %0d trace checks, %0d bound assertion failures",
               errors, checks, assert_errors);
      if (errors == 0 && assert_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== testbench/chord_player_asserts.sv ====
`timescale 1ns/1ns

module chord_player_asserts (
   input logic                               clk,
   input logic                               arst_n,
   input logic                               generate_next_sample,
   input logic                               sample_ready,
   input logic signed [chord_pkg::mix_w-1:0] final_sample,
   input logic                               play_enable
);

   int failures = 0;                   // Read by the testbench at the end of the run

   property ready_single_pulse;
      @(posedge clk) disable iff (!arst_n)
         sample_ready |=> !sample_ready;
   endproperty

   property ready_after_request;
      @(posedge clk) disable iff (!arst_n)
         generate_next_sample |-> ##3 sample_ready;
   endproperty

   property ready_has_request;
      @(posedge clk) disable iff (!arst_n)
         sample_ready |-> $past(generate_next_sample, 3);
   endproperty

   // A sum built while disabled carries silence
   property silent_when_disabled;
      @(posedge clk) disable iff (!arst_n)
         !play_enable ##1 sample_ready |-> final_sample == '0;
   endproperty

   assert property (ready_single_pulse) else begin
      failures++;
      $error("sample_ready high on two cycles in a row");
   end

   assert property (ready_after_request) else begin
      failures++;
      $error("sample_ready missing 3 cycles after generate_next_sample");
   end

   assert property (ready_has_request) else begin
      failures++;
      $error("sample_ready without generate_next_sample 3 cycles before");
   end

   assert property (silent_when_disabled) else begin
      failures++;
      $error("final_sample not 0 for a sample computed with play_enable low");
   end

endmodule

bind chord_player chord_player_asserts u_asserts (
   .clk                  (clk),
   .arst_n               (arst_n),
   .generate_next_sample (generate_next_sample),
   .sample_ready         (sample_ready),
   .final_sample         (final_sample),
   .play_enable          (cfg.play_enable)
);

// ==== rtl/chord_player.sv ====
`timescale 1ns/1ns

module chord_player (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               cfg_write,
   input  chord_pkg::player_cfg_t             cfg_data,
   input  logic                               load_new_note,
   input  chord_pkg::note_cmd_t               note_cmd,
   input  logic                               activate,
   input  logic                               beat,
   input  logic                               generate_next_sample,
   output logic signed [chord_pkg::mix_w-1:0] final_sample,
   output logic                               sample_ready,
   output logic                               note_done
);
   import chord_pkg::*;

   player_cfg_t               cfg;
   voice_load_t               voice_cmd    [num_voices];
   logic signed [voice_w-1:0] voice_sample [num_voices];
   logic [num_voices-1:0]     voice_ready;

   chord_config u_config (
      .clk                  (clk),
      .arst_n               (arst_n),
      .cfg_write            (cfg_write),
      .cfg_data             (cfg_data),
      .generate_next_sample (generate_next_sample),
      .cfg                  (cfg)
   );

   voice_allocator u_allocator (
      .clk           (clk),
      .arst_n        (arst_n),
      .cfg           (cfg),
      .note_cmd      (note_cmd),
      .load_new_note (load_new_note),
      .activate      (activate),
      .beat          (beat),
      .voice_cmd     (voice_cmd),
      .note_done     (note_done)
   );

   for (genvar i = 0; i < num_voices; i++) begin : g_voice
      note_player u_player (
         .clk                  (clk),
         .arst_n               (arst_n),
         .cfg                  (cfg),
         .voice_cmd            (voice_cmd[i]),
         .generate_next_sample (generate_next_sample),
         .voice_sample         (voice_sample[i]),
         .voice_ready          (voice_ready[i])
      );
   end

   sample_mixer u_mixer (
      .clk          (clk),
      .arst_n       (arst_n),
      .voice_sample (voice_sample),
      .voice_ready  (voice_ready),
      .final_sample (final_sample),
      .sample_ready (sample_ready)
   );

endmodule

// ==== rtl/sample_mixer.sv ====
`timescale 1ns/1ns

module sample_mixer (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic signed [chord_pkg::voice_w-1:0] voice_sample [chord_pkg::num_voices],
   input  logic [chord_pkg::num_voices-1:0]     voice_ready,
   output logic signed [chord_pkg::mix_w-1:0]   final_sample,
   output logic                                 sample_ready
);
   import chord_pkg::*;

   logic signed [voice_w-1:0] held [num_voices];  // Last captured sample per voice
   logic [num_voices-1:0]     arrived;
   logic [num_voices-1:0]     have;
   logic signed [mix_w-1:0]   sum;

   // A voice arriving this cycle counts directly without waiting for its capture
   always_comb begin
      logic signed [voice_w-1:0] pick;
      have = arrived | voice_ready;
      sum  = '0;
      for (int i = 0; i < num_voices; i++) begin
         pick = voice_ready[i] ? voice_sample[i] : held[i];
         sum  = sum + mix_w'(pick);
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < num_voices; i++) begin
         if (voice_ready[i]) begin
            held[i] <= voice_sample[i];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         arrived      <= '0;
         sample_ready <= 1'b0;
         final_sample <= '0;
      end else begin
         sample_ready <= &have;
         arrived      <= (&have) ? '0 : have;
         if (&have) begin
            final_sample <= sum;               // Held until the next full set
         end
      end
   end

endmodule

// ==== rtl/note_player.sv ====
`timescale 1ns/1ns

module note_player (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  chord_pkg::player_cfg_t               cfg,
   input  chord_pkg::voice_load_t               voice_cmd,
   input  logic                                 generate_next_sample,
   output logic signed [chord_pkg::voice_w-1:0] voice_sample,
   output logic                                 voice_ready
);
   import chord_pkg::*;

   logic [phase_w-1:0]        step;
   logic [phase_w-1:0]        phase_fund;
   logic [phase_w-1:0]        phase_harm;     // Runs at twice the fundamental rate
   logic                      req_d1;
   logic                      req_d2;
   logic signed [voice_w-1:0] fund;
   logic signed [voice_w-1:0] harm;
   logic signed [voice_w+1:0] mix;

   sine_rom u_rom (
      .clk      (clk),
      .phase_a  (phase_fund[phase_w-1 -: rom_addr_w+2]),
      .phase_b  (phase_harm[phase_w-1 -: rom_addr_w+2]),
      .sample_a (fund),
      .sample_b (harm)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         step       <= '0;
         phase_fund <= '0;
         phase_harm <= '0;
         req_d1     <= 1'b0;
         req_d2     <= 1'b0;
      end else begin
         req_d1 <= generate_next_sample;
         req_d2 <= req_d1;                 // ROM output is ready in this cycle
         if (voice_cmd.load) begin
            step       <= note_step[voice_cmd.note];
            phase_fund <= '0;
            phase_harm <= '0;
         end else if (generate_next_sample && cfg.play_enable) begin
            phase_fund <= phase_fund + step;
            phase_harm <= phase_harm + {step[phase_w-2:0], 1'b0};
         end
      end
   end

   always_comb begin
      case (cfg.weight)
         2'd0:    mix = (voice_w+2)'(fund);
         2'd1:    mix = (voice_w+2)'(fund) + (voice_w+2)'(harm >>> 2);
         2'd2:    mix = (voice_w+2)'(fund) + (voice_w+2)'(harm >>> 1);
         default: mix = ((voice_w+2)'(fund) + (voice_w+2)'(harm)) >>> 1;
      endcase

      // Clip into the voice range when the harmonic pushes past full scale
      if (mix[voice_w+1:voice_w-1] == '0 || mix[voice_w+1:voice_w-1] == '1) begin
         voice_sample = mix[voice_w-1:0];
      end else if (mix[voice_w+1]) begin
         voice_sample = {1'b1, {(voice_w-1){1'b0}}};
      end else begin
         voice_sample = {1'b0, {(voice_w-1){1'b1}}};
      end

      if (!cfg.play_enable) begin
         voice_sample = '0;
      end
   end

   assign voice_ready = req_d2;

endmodule

// ==== rtl/sine_rom.sv ====
`timescale 1ns/1ns

module sine_rom (
   input  logic                                clk,
   input  logic [chord_pkg::rom_addr_w+1:0]    phase_a,
   input  logic [chord_pkg::rom_addr_w+1:0]    phase_b,
   output logic signed [chord_pkg::voice_w-1:0] sample_a,
   output logic signed [chord_pkg::voice_w-1:0] sample_b
);
   import chord_pkg::*;

   typedef logic [voice_w-2:0] quarter_t [2**rom_addr_w];

   // Bhaskara approximation where a half cycle spans 2**(rom_addr_w+2) units
   function automatic quarter_t build_quarter();
      quarter_t tbl;
      longint   n;
      longint   amp;
      longint   p;
      longint   q;
      n   = 2**(rom_addr_w + 2);
      amp = 2**(voice_w - 1) - 1;
      for (int x = 0; x < 2**rom_addr_w; x++) begin
         p      = 2 * x;
         q      = p * (n - p);
         tbl[x] = (voice_w-1)'((amp * 16 * q) / (5 * n * n - 4 * q));
      end
      return tbl;
   endfunction

   localparam quarter_t quarter_rom = build_quarter();

   function automatic logic signed [voice_w-1:0] lookup(input logic [rom_addr_w+1:0] ph);
      logic [rom_addr_w-1:0]      addr;
      logic signed [voice_w-1:0]  mag;
      addr = ph[rom_addr_w] ? ~ph[rom_addr_w-1:0] : ph[rom_addr_w-1:0];  // Falling quarter
      mag  = signed'({1'b0, quarter_rom[addr]});
      return ph[rom_addr_w+1] ? -mag : mag;                              // Second half is negative
   endfunction

   always_ff @(posedge clk) begin
      sample_a <= lookup(phase_a);
      sample_b <= lookup(phase_b);
   end

endmodule

// ==== rtl/voice_allocator.sv ====
`timescale 1ns/1ns

module voice_allocator (
   input  logic                   clk,
   input  logic                   arst_n,
   input  chord_pkg::player_cfg_t cfg,
   input  chord_pkg::note_cmd_t   note_cmd,
   input  logic                   load_new_note,
   input  logic                   activate,
   input  logic                   beat,
   output chord_pkg::voice_load_t voice_cmd [chord_pkg::num_voices],
   output logic                   note_done
);
   import chord_pkg::*;

   logic [dur_w-1:0]      chord_cnt;            // Chord timer
   logic [dur_w-1:0]      voice_cnt [num_voices];
   logic [num_voices-1:0] voice_idle;
   logic [num_voices-1:0] load_voice;
   logic                  load_chord;
   logic                  tick;

   assign tick = beat && cfg.play_enable;

   // Chord timer first when asked for, then voices 1, 2 and 3
   always_comb begin : route
      logic taken;
      taken      = !(load_new_note && cfg.play_enable);
      load_chord = 1'b0;
      load_voice = '0;
      if (!taken && activate && chord_cnt == '0) begin
         load_chord = 1'b1;
         taken      = 1'b1;
      end
      for (int i = 0; i < num_voices; i++) begin
         voice_idle[i] = (voice_cnt[i] == '0);
         if (!taken && voice_idle[i]) begin
            load_voice[i] = 1'b1;
            taken         = 1'b1;
         end
         voice_cmd[i].load = load_voice[i];
         voice_cmd[i].note = load_voice[i] ? note_cmd.note : '0;  // Only the chosen voice sees it
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         chord_cnt <= '0;
         voice_cnt <= '{default: '0};
      end else begin
         if (load_chord) begin
            chord_cnt <= note_cmd.duration;
         end else if (tick && chord_cnt != '0) begin
            chord_cnt <= chord_cnt - 1'b1;
         end
         for (int i = 0; i < num_voices; i++) begin
            if (load_voice[i]) begin
               voice_cnt[i] <= note_cmd.duration;
            end else if (tick && chord_cnt != '0 && !voice_idle[i]) begin
               voice_cnt[i] <= voice_cnt[i] - 1'b1;  // Frozen while the chord timer is idle
            end
         end
      end
   end

   assign note_done = (chord_cnt == '0) || (|voice_idle);

endmodule

// ==== rtl/chord_config.sv ====
`timescale 1ns/1ns

module chord_config (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   cfg_write,
   input  chord_pkg::player_cfg_t cfg_data,
   input  logic                   generate_next_sample,
   output chord_pkg::player_cfg_t cfg
);

   logic [1:0] weight_shadow;           // Pending weight for the next sample request

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg           <= '0;
         weight_shadow <= '0;
      end else begin
         if (cfg_write) begin
            cfg.play_enable <= cfg_data.play_enable;
            weight_shadow   <= cfg_data.weight;
         end
         // Weight only moves between samples so a sample in flight keeps one mix
         if (generate_next_sample) begin
            if (cfg_write) begin
               cfg.weight <= cfg_data.weight;
            end else begin
               cfg.weight <= weight_shadow;
            end
         end
      end
   end

endmodule

// ==== rtl/chord_pkg.sv ====
package chord_pkg;

   localparam int note_w     = 6;
   localparam int dur_w      = 6;
   localparam int voice_w    = 16;
   localparam int mix_w      = 18;
   localparam int phase_w    = 20;
   localparam int rom_addr_w = 8;
   localparam int num_voices = 3;

   typedef struct packed {
      logic [note_w-1:0] note;
      logic [dur_w-1:0]  duration;     // In 1/48 s beats
   } note_cmd_t;

   typedef struct packed {
      logic       play_enable;
      logic [1:0] weight;              // Second harmonic level
   } player_cfg_t;

   typedef struct packed {
      logic              load;
      logic [note_w-1:0] note;
   } voice_load_t;

   // Phase increment per sample at 48 kHz with note 1 as A1 at 55 Hz
   localparam logic [phase_w-1:0] note_step [2**note_w] = '{
          0,  1201,  1273,  1349,  1429,  1514,  1604,  1699,
       1800,  1907,  2021,  2141,  2268,  2403,  2546,  2697,
       2858,  3028,  3208,  3398,  3600,  3815,  4041,  4282,
       4536,  4806,  5092,  5394,  5715,  6055,  6415,  6797,
       7201,  7629,  8083,  8563,  9072,  9612, 10183, 10789,
      11430, 12110, 12830, 13593, 14402, 15258, 16165, 17127,
      18145, 19224, 20367, 21578, 22861, 24220, 25661, 27187,
      28803, 30516, 32331, 34253, 36290, 38448, 40734, 43156
   };

endpackage
